// ==== verilog/ipod_pkg.sv ====
package ipod_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 16;
  localparam int DIV_W        = 16;

  // ====================================================================
  // Data types
  // ====================================================================
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Clock cycles between two sample requests
  typedef logic [DIV_W-1:0] div_t;

  // Active low, bit 0 drives segment a
  typedef logic [6:0] seg_t;

  // Avalon read master side
  typedef struct packed {
    logic                    read;
    logic [FLASH_ADDR_W-1:0] address;
  } flash_req_t;

  // Avalon slave side
  typedef struct packed {
    logic                    waitrequest;
    logic                    readdatavalid;
    logic [FLASH_DATA_W-1:0] readdata;
  } flash_rsp_t;

  typedef enum logic [1:0] {SPD_NONE, SPD_UP, SPD_DOWN, SPD_RESET} speed_cmd_e;

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_HIGH} reader_state_e;

  // ====================================================================
  // Defaults for a 50 MHz clock
  // ====================================================================
  // 50 MHz / 22 kHz
  localparam div_t DEFAULT_SAMPLE_DIV  = 16'd2272;
  localparam div_t DEFAULT_SPEED_STEP  = 16'd100;
  // Ten repeats per second
  localparam int   DEFAULT_HOLD_CYCLES = 5_000_000;

endpackage

// ==== verilog/speed_control.sv ====
`timescale 1ns/1ps

module speed_control #(
  parameter ipod_pkg::div_t DEFAULT_DIV = ipod_pkg::DEFAULT_SAMPLE_DIV,
  parameter ipod_pkg::div_t MIN_DIV     = 16'd1136,
  parameter ipod_pkg::div_t MAX_DIV     = 16'd9088,
  parameter ipod_pkg::div_t SPEED_STEP  = ipod_pkg::DEFAULT_SPEED_STEP,
  parameter int             HOLD_CYCLES = ipod_pkg::DEFAULT_HOLD_CYCLES
) (
  input  logic           CLK_50M,
  input  logic           rst_n,
  input  logic [2:0]     key_n,
  output ipod_pkg::div_t div_count
);

  import ipod_pkg::*;

  localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

  // Key bits: 0 faster, 1 slower, 2 default; all held high here
  logic [2:0]        key_meta;
  logic [2:0]        key_sync;
  logic [2:0]        key_prev;
  logic [2:0]        key_first;
  logic [2:0]        key_act;
  logic [HOLD_W-1:0] hold_cnt;
  logic              repeat_tick;
  speed_cmd_e        speed_cmd;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign key_first   = key_sync & ~key_prev;
  assign repeat_tick = (key_sync != '0) && (key_first == '0) &&
                       (hold_cnt == HOLD_W'(HOLD_CYCLES - 1));

  // Repeat timer restarts on every new press
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      hold_cnt <= '0;
    else if (key_sync == '0 || key_first != '0 || repeat_tick)
      hold_cnt <= '0;
    else
      hold_cnt <= hold_cnt + 1'b1;
  end

  // Default beats faster, faster beats slower
  always_comb
  begin
    key_act = key_first | (repeat_tick ? key_sync : 3'b000);
    if (key_act[2])
      speed_cmd = SPD_RESET;
    else if (key_act[0])
      speed_cmd = SPD_UP;
    else if (key_act[1])
      speed_cmd = SPD_DOWN;
    else
      speed_cmd = SPD_NONE;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      div_count <= DEFAULT_DIV;
    else
    begin
      case (speed_cmd)
        SPD_UP:    div_count <= (div_count < MIN_DIV + SPEED_STEP) ?
                                MIN_DIV : div_count - SPEED_STEP;
        SPD_DOWN:  div_count <= (div_count > MAX_DIV - SPEED_STEP) ?
                                MAX_DIV : div_count + SPEED_STEP;
        SPD_RESET: div_count <= DEFAULT_DIV;
        default:   div_count <= div_count;
      endcase
    end
  end

  a_div_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    div_count >= MIN_DIV && div_count <= MAX_DIV);

endmodule

// ==== verilog/flash_reader.sv ====
`timescale 1ns/1ps

module flash_reader #(
  parameter logic [ipod_pkg::FLASH_ADDR_W-1:0] LAST_ADDR = 23'h7FFFF
) (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  logic                 restart_n,
  input  logic                 sample_req,
  input  ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::flash_req_t flash_req,
  output logic                 sample_valid,
  output ipod_pkg::sample_t    sample_data
);

  import ipod_pkg::*;

  reader_state_e           state;
  logic [FLASH_ADDR_W-1:0] word_addr;
  logic [FLASH_ADDR_W-1:0] next_addr;
  sample_t                 high_buf;
  logic                    discard;
  logic                    restart_meta;
  logic                    restart_sync;
  logic                    restart_prev;
  logic                    restart_evt;

  // Restart key synchronizer and edge detect
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      restart_meta <= 1'b0;
      restart_sync <= 1'b0;
      restart_prev <= 1'b0;
    end
    else
    begin
      restart_meta <= ~restart_n;
      restart_sync <= restart_meta;
      restart_prev <= restart_sync;
    end
  end

  assign restart_evt = restart_sync & ~restart_prev;
  assign next_addr   = restart_evt ? '0 : word_addr;

  // ====================================================================
  // Read FSM
  // ====================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= RD_IDLE;
      word_addr    <= '0;
      flash_req    <= '0;
      sample_valid <= 1'b0;
      discard      <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (restart_evt)
        word_addr <= '0;
      case (state)
        RD_IDLE:
          if (sample_req)
          begin
            flash_req.read    <= 1'b1;
            flash_req.address <= next_addr;
            discard           <= 1'b0;
            state             <= RD_REQ;
          end
        RD_REQ:
        begin
          // Read in flight keeps going, its data is dropped
          if (restart_evt)
            discard <= 1'b1;
          if (!flash_rsp.waitrequest)
          begin
            flash_req.read <= 1'b0;
            state          <= RD_WAIT;
          end
        end
        RD_WAIT:
        begin
          if (restart_evt)
            discard <= 1'b1;
          if (flash_rsp.readdatavalid)
          begin
            sample_valid <= !(discard || restart_evt);
            state        <= (discard || restart_evt) ? RD_IDLE : RD_HIGH;
          end
        end
        RD_HIGH:
          if (restart_evt)
          begin
            flash_req.read    <= sample_req;
            flash_req.address <= '0;
            state             <= sample_req ? RD_REQ : RD_IDLE;
          end
          else if (sample_req)
          begin
            sample_valid <= 1'b1;
            word_addr    <= (word_addr == LAST_ADDR) ? '0 : word_addr + 1'b1;
            state        <= RD_IDLE;
          end
        default:
          state <= RD_IDLE;
      endcase
    end
  end

  // Low half goes out at once, high half waits for the next request
  always_ff @(posedge CLK_50M)
  begin
    if (state == RD_WAIT && flash_rsp.readdatavalid)
    begin
      sample_data <= sample_t'(flash_rsp.readdata[SAMPLE_W-1:0]);
      high_buf    <= sample_t'(flash_rsp.readdata[FLASH_DATA_W-1:SAMPLE_W]);
    end
    else if (state == RD_HIGH && sample_req)
      sample_data <= high_buf;
  end

  a_addr_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=>
      flash_req.read && $stable(flash_req.address));

  a_req_when_free: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_req |-> state inside {RD_IDLE, RD_HIGH});

endmodule

// ==== verilog/sample_pacer.sv ====
`timescale 1ns/1ps

module sample_pacer (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              play,
  input  ipod_pkg::div_t    div_count,
  input  logic              sample_valid,
  input  ipod_pkg::sample_t sample_data,
  output logic              sample_req,
  output ipod_pkg::sample_t audio_sample,
  output logic              audio_strobe
);

  import ipod_pkg::*;

  div_t pace_cnt;

  // Request pacing, frozen while paused
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pace_cnt   <= '0;
      sample_req <= 1'b0;
    end
    else if (!play)
      sample_req <= 1'b0;
    else if (pace_cnt == '0)
    begin
      // Divider picked up here, once per request
      pace_cnt   <= div_count - 1'b1;
      sample_req <= 1'b1;
    end
    else
    begin
      pace_cnt   <= pace_cnt - 1'b1;
      sample_req <= 1'b0;
    end
  end

  // Output register holds the last sample between strobes
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      audio_sample <= '0;
      audio_strobe <= 1'b0;
    end
    else
    begin
      audio_strobe <= sample_valid;
      if (sample_valid)
        audio_sample <= sample_data;
    end
  end

endmodule

// ==== verilog/hex_display.sv ====
`timescale 1ns/1ps

module hex_display #(
  parameter int REFRESH_CYCLES = 25_000_000
) (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  ipod_pkg::div_t       div_count,
  output ipod_pkg::seg_t [5:0] hex
);

  import ipod_pkg::*;

  localparam int DIGITS    = 6;
  localparam int REFRESH_W = $clog2(REFRESH_CYCLES + 1);

  logic [REFRESH_W-1:0] refresh_cnt;
  logic [4*DIGITS-1:0]  disp_val;

  // Standard 0-F glyphs, segment on when low
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      disp_val    <= '0;
    end
    else if (refresh_cnt == REFRESH_W'(REFRESH_CYCLES - 1))
    begin
      refresh_cnt <= '0;
      disp_val    <= {{(4*DIGITS-DIV_W){1'b0}}, div_count};
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  for (genvar i = 0; i < DIGITS; i++)
  begin : g_digit
    assign hex[i] = seg_decode(disp_val[4*i +: 4]);
  end

endmodule

// ==== verilog/simple_ipod.sv ====
`timescale 1ns/1ps

module simple_ipod #(
  parameter ipod_pkg::div_t DEFAULT_DIV = ipod_pkg::DEFAULT_SAMPLE_DIV,
  parameter ipod_pkg::div_t MIN_DIV     = 16'd1136,
  parameter ipod_pkg::div_t MAX_DIV     = 16'd9088,
  parameter ipod_pkg::div_t SPEED_STEP  = ipod_pkg::DEFAULT_SPEED_STEP,
  parameter int             HOLD_CYCLES = ipod_pkg::DEFAULT_HOLD_CYCLES,
  parameter logic [ipod_pkg::FLASH_ADDR_W-1:0] LAST_ADDR = 23'h7FFFF,
  parameter int             REFRESH_CYCLES = 25_000_000
) (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  logic [2:0]           key_n,
  input  logic                 restart_n,
  input  logic                 play,
  input  ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::sample_t    audio_sample,
  output logic                 audio_strobe,
  output ipod_pkg::seg_t [5:0] hex
);

  import ipod_pkg::*;

  div_t    div_count;
  logic    sample_req;
  logic    sample_valid;
  sample_t sample_data;

  // ====================================================================
  // Speed control and flash reading, joined by the pacer
  // ====================================================================
  speed_control #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .HOLD_CYCLES (HOLD_CYCLES)
  ) speed_control_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key_n     (key_n),
    .div_count (div_count)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) flash_reader_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .restart_n    (restart_n),
    .sample_req   (sample_req),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample_valid (sample_valid),
    .sample_data  (sample_data)
  );

  sample_pacer sample_pacer_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .play         (play),
    .div_count    (div_count),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_req   (sample_req),
    .audio_sample (audio_sample),
    .audio_strobe (audio_strobe)
  );

  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) hex_display_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .div_count (div_count),
    .hex       (hex)
  );

endmodule

// ==== tests/tb_simple_ipod.sv ====
`timescale 1ns/1ps

module tb_simple_ipod;

  import ipod_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int DEF_DIV    = 40;
  localparam int MIN_DIV    = 24;
  localparam int MAX_DIV    = 64;
  localparam int STEP       = 8;
  localparam int HOLD       = 30;
  localparam int LAST_ADDR  = 15;
  localparam int REFRESH    = 16;
  localparam int SETTLE     = 40;
  localparam int N_RANDOM   = 12;
  localparam int TEST_CYCLES = 40 * MAX_DIV + (N_RANDOM + 3) * 640 + 2000;
  localparam logic [31:0] SEED = 32'h5454_ade1;
  // Lit segments gfedcba for 0-F, inverted for the board
  localparam logic [6:0] SEG_ON [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
    7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  logic [2:0]  key_n;
  logic        restart_n;
  logic        play;
  flash_rsp_t  flash_rsp = '0;
  flash_req_t  flash_req;
  sample_t     audio_sample;
  logic        audio_strobe;
  seg_t [5:0]  hex;

  // Flash model state
  logic [31:0]             flash_rng = SEED;
  logic [FLASH_ADDR_W-1:0] acc_addr;
  int                      wait_left;
  int                      lat_left;
  // Monitor state
  int      cycle;
  int      strobe_count;
  int      high_count;
  int      high_spacing;
  int      last_high;
  int      seq_errors;
  sample_t exp_sample;
  // Main sequence state
  int          strobe_base;
  int          exp_div;
  int          chk_errors;
  int          hold;
  int          cnt0;
  logic [1:0]  key;
  logic [31:0] stim_rng;

  simple_ipod #(
    .DEFAULT_DIV    (16'(DEF_DIV)),
    .MIN_DIV        (16'(MIN_DIV)),
    .MAX_DIV        (16'(MAX_DIV)),
    .SPEED_STEP     (16'(STEP)),
    .HOLD_CYCLES    (HOLD),
    .LAST_ADDR      (23'(LAST_ADDR)),
    .REFRESH_CYCLES (REFRESH)
  ) simple_ipod_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key_n        (key_n),
    .restart_n    (restart_n),
    .play         (play),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .audio_sample (audio_sample),
    .audio_strobe (audio_strobe),
    .hex          (hex)
  );

  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Low half then high half of each word, song wraps after the last word
  function automatic sample_t expected_sample(input int idx);
    logic [31:0] word;
    word = xorshift(32'((idx / 2) % (LAST_ADDR + 1)) + SEED);
    return (idx % 2 == 1) ? sample_t'(word[31:16]) : sample_t'(word[15:0]);
  endfunction

  function automatic int next_div(input int d, input logic [1:0] k);
    if (k == 2'd0)
      return (d - STEP < MIN_DIV) ? MIN_DIV : d - STEP;
    else if (k == 2'd1)
      return (d + STEP > MAX_DIV) ? MAX_DIV : d + STEP;
    return DEF_DIV;
  endfunction

  // ====================================================================
  // Flash device, random waitrequest and read latency
  // ====================================================================
  always @(posedge CLK_50M)
  begin
    flash_rsp.readdatavalid <= 1'b0;
    if (lat_left > 0)
    begin
      lat_left = lat_left - 1;
      if (lat_left == 0)
      begin
        flash_rsp.readdatavalid <= 1'b1;
        flash_rsp.readdata      <= xorshift(32'(acc_addr) + SEED);
      end
    end
    if (flash_req.read && !flash_rsp.waitrequest)
    begin
      acc_addr  = flash_req.address;
      flash_rng = xorshift(flash_rng);
      lat_left  = 1 + int'(flash_rng[1:0]);
      // Stall length for the next read
      wait_left = int'(flash_rng[5:4]);
      flash_rsp.waitrequest <= (wait_left != 0);
    end
    else if (flash_req.read)
    begin
      wait_left = wait_left - 1;
      flash_rsp.waitrequest <= (wait_left != 0);
    end
  end

  // Sample order check and spacing of high-half strobes
  always @(posedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (rst_n && audio_strobe)
    begin
      exp_sample = expected_sample(strobe_count - strobe_base);
      assert (audio_sample == exp_sample)
      else
      begin
        seq_errors = seq_errors + 1;
        $display("FAIL %0t audio_sample got %h expected %h", $time, audio_sample, exp_sample);
      end
      if ((strobe_count - strobe_base) % 2 == 1)
      begin
        high_spacing = cycle - last_high;
        last_high    = cycle;
        high_count   = high_count + 1;
      end
      strobe_count = strobe_count + 1;
    end
  end

  task automatic check_display(input int div);
    logic [2:0] d;
    logic [3:0] nib;
    for (d = 0; d < 6; d++)
    begin
      nib = 4'(div >> (4 * d));
      assert (hex[d] == ~SEG_ON[nib])
      else
      begin
        chk_errors++;
        $display("FAIL %0t hex[%0d] got %h expected %h", $time, d, hex[d], ~SEG_ON[nib]);
      end
    end
  endtask

  // Two requests per high-half period, the high strobe trails its request by a fixed delay
  task automatic check_rate(input int div);
    int hc0;
    hc0 = high_count;
    wait (high_count >= hc0 + 2);
    assert (high_spacing == 2 * div)
    else
    begin
      chk_errors++;
      $display("FAIL %0t audio_strobe_spacing got %0d expected %0d", $time, high_spacing,
               2 * div);
    end
  endtask

  // Hold times stay clear of repeat period boundaries
  task automatic press_and_check(input logic [1:0] k, input int cycles);
    int steps;
    steps = 1 + cycles / HOLD;
    @(posedge CLK_50M);
    key_n[k] <= 1'b0;
    repeat (cycles) @(posedge CLK_50M);
    key_n[k] <= 1'b1;
    repeat (steps) exp_div = next_div(exp_div, k);
    repeat (SETTLE) @(posedge CLK_50M);
    check_display(exp_div);
    check_rate(exp_div);
  endtask

  task automatic report_and_finish(input bit timed_out);
    $display("Sequence errors %0d, rate and display errors %0d, timeout %0d",
             seq_errors, chk_errors, timed_out);
    if (!timed_out && seq_errors == 0 && chk_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial
  begin
    rst_n     = 1'b0;
    key_n     = 3'b111;
    restart_n = 1'b1;
    play      = 1'b0;
    stim_rng  = SEED;
    exp_div   = DEF_DIV;
    repeat (2) @(posedge CLK_50M);
    rst_n <= 1'b1;
    play  <= 1'b1;
    @(posedge CLK_50M);
    assert (audio_sample == '0)
    else
    begin
      chk_errors++;
      $display("FAIL %0t audio_sample got %h expected 0000", $time, audio_sample);
    end
    check_display(0);
    wait (strobe_count >= 40);
    check_rate(exp_div);

    // Clamp at both ends, then back to default
    press_and_check(2'd1, 5 * HOLD + 15);
    press_and_check(2'd0, 5 * HOLD + 15);
    press_and_check(2'd2, 5);
    for (int n = 0; n < N_RANDOM; n++)
    begin
      stim_rng = xorshift(stim_rng);
      key = stim_rng[1:0];
      if (key == 2'd3)
        key = 2'd0;
      if (stim_rng[4])
        hold = HOLD * (1 + int'(stim_rng[8])) + 10 + int'(stim_rng[15:12]) % 10;
      else
        hold = 2 + int'(stim_rng[20:16]) % 25;
      press_and_check(key, hold);
    end

    // Pause, restart, resume from word 0
    // Pause right after a low half so a high half is left pending
    wait (strobe_count % 2 == 0);
    wait (strobe_count % 2 == 1);
    @(posedge CLK_50M);
    play <= 1'b0;
    repeat (20) @(posedge CLK_50M);
    cnt0 = strobe_count;
    repeat (150) @(posedge CLK_50M);
    assert (strobe_count == cnt0)
    else
    begin
      chk_errors++;
      $display("Audio strobes kept coming while play was low");
    end
    restart_n <= 1'b0;
    repeat (4) @(posedge CLK_50M);
    restart_n <= 1'b1;
    repeat (6) @(posedge CLK_50M);
    strobe_base = strobe_count;
    play <= 1'b1;
    wait (strobe_count >= strobe_base + 12);
    check_rate(exp_div);
    report_and_finish(1'b0);
  end

  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    report_and_finish(1'b1);
  end

endmodule

// ==== sources.f ====
verilog/ipod_pkg.sv
verilog/speed_control.sv
verilog/flash_reader.sv
verilog/sample_pacer.sv
verilog/hex_display.sv
verilog/simple_ipod.sv
tests/tb_simple_ipod.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_simple_ipod
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  := ALL CHECKS PASSED
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
